/* rv_settings.svh */
/* rv32i core settings
   widths, reset vector and base opcode values shared by the core */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define RV_XLEN      32
`define RV_REG_COUNT 32
`define RV_RESET_PC  32'h8000_0000

// base opcode map, inst[6:0]
`define RV_OP_OP     7'b0110011
`define RV_OP_OP_IMM 7'b0010011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111

`endif

/* rv_pkg.sv */
/* rv32i core types
   data words, register numbers, decode enums and instruction format views */
`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_idx_t;
    typedef logic [3:0]          byte_mask_t;

    typedef enum logic [2:0] {
        CLASS_R,
        CLASS_I,
        CLASS_S,
        CLASS_B,
        CLASS_U,
        CLASS_J,
        CLASS_NONE     // unsupported opcode
    } inst_class_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset bits scattered around rs1/rs2
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six ways to read it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_word_u;

endpackage

/* rv_decode_if.sv */
/* decode bus
   decoded control from the decoder to execute and load/store */
interface rv_decode_if;

    rv_pkg::inst_class_t inst_class;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    rv_pkg::reg_idx_t    rd;
    rv_pkg::reg_idx_t    rs1;
    rv_pkg::reg_idx_t    rs2;
    rv_pkg::word_t       imm;     // already sign extended
    rv_pkg::alu_op_t     alu_op;

    modport decoder (
        output inst_class, opcode, funct3, rd, rs1, rs2, imm, alu_op
    );

    modport exec (
        input inst_class, opcode, funct3, imm, alu_op
    );

    // rd only gates the writeback enable
    modport lsu (
        input inst_class, opcode, funct3, rd
    );

endinterface

/* fetch_unit.sv */
/* fetch unit
   program counter register and next-pc selection */
`include "rv_settings.svh"

module fetch_unit (
    input  logic          clk,
    input  logic          reset,
    input  logic          jump_en,
    input  rv_pkg::word_t jump_target,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t snpc
);

    rv_pkg::word_t dnpc;

    assign snpc = pc + 4;    // sequential successor
    assign dnpc = jump_en ? jump_target : snpc;

    // one instruction retires per edge, no stall
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= dnpc;
        end
    end

endmodule

/* decode_unit.sv */
/* decode unit
   instruction class, immediate assembly and alu operation from one word */
`include "rv_settings.svh"

module decode_unit (
    input rv_pkg::inst_word_u inst,
    rv_decode_if.decoder      dec
);

    logic [6:0] opcode;
    logic       funct7_b5;   // sub / sra select

    assign opcode    = inst.r.opcode;
    assign funct7_b5 = inst.r.funct7[5];

    // register fields sit at the same place in every format
    assign dec.opcode = opcode;
    assign dec.funct3 = inst.r.funct3;
    assign dec.rd     = inst.r.rd;
    assign dec.rs1    = inst.r.rs1;
    assign dec.rs2    = inst.r.rs2;

    always_comb begin
        unique case (opcode)
            `RV_OP_OP:                            dec.inst_class = rv_pkg::CLASS_R;
            `RV_OP_OP_IMM, `RV_OP_LOAD, `RV_OP_JALR: dec.inst_class = rv_pkg::CLASS_I;
            `RV_OP_STORE:                         dec.inst_class = rv_pkg::CLASS_S;
            `RV_OP_BRANCH:                        dec.inst_class = rv_pkg::CLASS_B;
            `RV_OP_LUI, `RV_OP_AUIPC:             dec.inst_class = rv_pkg::CLASS_U;
            `RV_OP_JAL:                           dec.inst_class = rv_pkg::CLASS_J;
            default:                              dec.inst_class = rv_pkg::CLASS_NONE;
        endcase
    end

    // immediates, sign taken from inst[31] in every view
    always_comb begin
        unique case (dec.inst_class)
            rv_pkg::CLASS_I: dec.imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            rv_pkg::CLASS_S: dec.imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            rv_pkg::CLASS_B: begin
                dec.imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                           inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            end
            rv_pkg::CLASS_U: dec.imm = {inst.u.imm_31_12, 12'b0};
            rv_pkg::CLASS_J: begin
                dec.imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                           inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            end
            default:         dec.imm = '0;
        endcase
    end

    // address and link sums default to add
    always_comb begin
        dec.alu_op = rv_pkg::ALU_ADD;
        if (opcode == `RV_OP_OP || opcode == `RV_OP_OP_IMM) begin
            unique case (inst.r.funct3)
                3'b000: begin
                    // addi has no sub form
                    if (dec.inst_class == rv_pkg::CLASS_R && funct7_b5) begin
                        dec.alu_op = rv_pkg::ALU_SUB;
                    end
                end
                3'b001: dec.alu_op = rv_pkg::ALU_SLL;
                3'b010: dec.alu_op = rv_pkg::ALU_SLT;
                3'b011: dec.alu_op = rv_pkg::ALU_SLTU;
                3'b100: dec.alu_op = rv_pkg::ALU_XOR;
                3'b101: dec.alu_op = funct7_b5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110: dec.alu_op = rv_pkg::ALU_OR;
                3'b111: dec.alu_op = rv_pkg::ALU_AND;
                default: dec.alu_op = rv_pkg::ALU_ADD;
            endcase
        end
    end

endmodule

/* reg_file.sv */
/* general register file
   32 entries, two combinational reads, x0 hardwired to zero */
`include "rv_settings.svh"

module reg_file (
    input  logic             clk,
    input  logic             reset,
    input  logic             we,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::reg_idx_t raddr1,
    input  rv_pkg::reg_idx_t raddr2,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);

    rv_pkg::word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin   // x0 never written
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* execute_unit.sv */
/* execute unit
   operand selection, alu, branch compare and jump target */
`include "rv_settings.svh"

module execute_unit (
    rv_decode_if.exec     dec,
    input  rv_pkg::word_t rdata1,
    input  rv_pkg::word_t rdata2,
    input  rv_pkg::word_t pc,
    output rv_pkg::word_t alu_result,
    output rv_pkg::word_t jump_target,
    output logic          jump_en
);

    rv_pkg::word_t alu_a;
    rv_pkg::word_t alu_b;
    logic [4:0]    shamt;
    logic          lt_signed;
    logic          lt_unsigned;
    logic          branch_taken;

    // operand select by class
    always_comb begin
        unique case (dec.inst_class)
            rv_pkg::CLASS_R: begin
                alu_a = rdata1;
                alu_b = rdata2;
            end
            rv_pkg::CLASS_I, rv_pkg::CLASS_S: begin
                alu_a = rdata1;
                alu_b = dec.imm;
            end
            rv_pkg::CLASS_U: begin
                alu_a = (dec.opcode == `RV_OP_LUI) ? '0 : pc;  // lui vs auipc
                alu_b = dec.imm;
            end
            rv_pkg::CLASS_J, rv_pkg::CLASS_B: begin
                alu_a = pc;
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rdata1;
                alu_b = rdata2;
            end
        endcase
    end

    assign shamt       = alu_b[4:0];
    assign lt_signed   = $signed(alu_a) < $signed(alu_b);
    assign lt_unsigned = alu_a < alu_b;

    always_comb begin
        unique case (dec.alu_op)
            rv_pkg::ALU_ADD:  alu_result = alu_a + alu_b;
            rv_pkg::ALU_SUB:  alu_result = alu_a - alu_b;
            rv_pkg::ALU_SLL:  alu_result = alu_a << shamt;
            rv_pkg::ALU_SLT:  alu_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            rv_pkg::ALU_SLTU: alu_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            rv_pkg::ALU_XOR:  alu_result = alu_a ^ alu_b;
            rv_pkg::ALU_SRL:  alu_result = alu_a >> shamt;
            rv_pkg::ALU_SRA:  alu_result = rv_pkg::word_t'($signed(alu_a) >>> shamt);
            rv_pkg::ALU_OR:   alu_result = alu_a | alu_b;
            rv_pkg::ALU_AND:  alu_result = alu_a & alu_b;
            default:          alu_result = alu_a + alu_b;
        endcase
    end

    // branch condition on the register operands, not the alu inputs
    always_comb begin
        unique case (dec.funct3)
            3'b000:  branch_taken = (rdata1 == rdata2);                    // beq
            3'b001:  branch_taken = (rdata1 != rdata2);                    // bne
            3'b100:  branch_taken = ($signed(rdata1) < $signed(rdata2));   // blt
            3'b101:  branch_taken = ($signed(rdata1) >= $signed(rdata2));  // bge
            3'b110:  branch_taken = (rdata1 < rdata2);                     // bltu
            3'b111:  branch_taken = (rdata1 >= rdata2);                    // bgeu
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_en     = 1'b0;
        jump_target = alu_result;   // pc + imm for jal and branches
        unique case (dec.inst_class)
            rv_pkg::CLASS_J: jump_en = 1'b1;
            rv_pkg::CLASS_B: jump_en = branch_taken;
            rv_pkg::CLASS_I: begin
                if (dec.opcode == `RV_OP_JALR) begin
                    jump_en     = 1'b1;
                    jump_target = {alu_result[`RV_XLEN-1:1], 1'b0};
                end
            end
            default: ;
        endcase
    end

endmodule

/* load_store_unit.sv */
/* load/store unit
   data memory access, load extension and writeback value selection */
`include "rv_settings.svh"

module load_store_unit (
    input  logic               reset,
    rv_decode_if.lsu           dec,
    input  rv_pkg::word_t      alu_result,
    input  rv_pkg::word_t      rdata2,
    input  rv_pkg::word_t      snpc,
    input  rv_pkg::word_t      dmem_rdata,
    output rv_pkg::word_t      dmem_addr,
    output rv_pkg::word_t      dmem_wdata,
    output rv_pkg::word_t      rd_wdata,
    output rv_pkg::byte_mask_t dmem_wmask,
    output logic               dmem_we,
    output logic               dmem_re,
    output logic               rd_we
);

    logic          is_load;
    logic          is_store;
    logic          load_ok;    // funct3 names a real load
    logic          wb_en;
    rv_pkg::word_t load_data;

    assign is_load  = (dec.inst_class == rv_pkg::CLASS_I) && (dec.opcode == `RV_OP_LOAD);
    assign is_store = (dec.inst_class == rv_pkg::CLASS_S) && (dec.opcode == `RV_OP_STORE);

    assign dmem_addr  = alu_result;
    assign dmem_wdata = rdata2;    // unshifted, mask picks the low bytes

    always_comb begin
        unique case (dec.funct3)
            3'b000:  dmem_wmask = 4'b0001;   // sb
            3'b001:  dmem_wmask = 4'b0011;   // sh
            3'b010:  dmem_wmask = 4'b1111;   // sw
            default: dmem_wmask = 4'b0000;
        endcase
    end

    assign dmem_we = !reset && is_store && (dmem_wmask != '0);
    assign dmem_re = !reset && is_load && load_ok;

    always_comb begin
        load_ok = 1'b1;
        unique case (dec.funct3)
            3'b000:  load_data = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};
            3'b001:  load_data = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};
            3'b010:  load_data = dmem_rdata;
            3'b100:  load_data = {24'b0, dmem_rdata[7:0]};
            3'b101:  load_data = {16'b0, dmem_rdata[15:0]};
            default: begin
                load_data = '0;
                load_ok   = 1'b0;
            end
        endcase
    end

    always_comb begin
        rd_wdata = alu_result;
        wb_en    = 1'b0;
        unique case (dec.inst_class)
            rv_pkg::CLASS_R: wb_en = 1'b1;
            rv_pkg::CLASS_I: begin
                if (is_load) begin
                    rd_wdata = load_data;
                    wb_en    = load_ok;
                end else if (dec.opcode == `RV_OP_JALR) begin
                    rd_wdata = snpc;     // link
                    wb_en    = 1'b1;
                end else begin
                    wb_en = (dec.opcode == `RV_OP_OP_IMM);
                end
            end
            rv_pkg::CLASS_U: wb_en = 1'b1;
            rv_pkg::CLASS_J: begin
                rd_wdata = snpc;
                wb_en    = 1'b1;
            end
            default: ;   // b, s and unsupported write nothing
        endcase
    end

    assign rd_we = !reset && wb_en && (dec.rd != '0);

endmodule

/* rv_core.sv */
/* single-cycle rv32i core
   fetch, decode, register file, execute and load/store in one cycle */
module rv_core (
    input  logic               clk,
    input  logic               reset,
    output rv_pkg::word_t      imem_addr,
    input  rv_pkg::word_t      imem_rdata,
    output rv_pkg::word_t      dmem_addr,
    output rv_pkg::word_t      dmem_wdata,
    output rv_pkg::byte_mask_t dmem_wmask,
    output logic               dmem_we,
    output logic               dmem_re,
    input  rv_pkg::word_t      dmem_rdata
);

    rv_pkg::word_t      pc;
    rv_pkg::word_t      snpc;
    rv_pkg::word_t      jump_target;
    logic               jump_en;
    rv_pkg::inst_word_u inst;
    rv_pkg::word_t      rdata1;
    rv_pkg::word_t      rdata2;
    rv_pkg::word_t      alu_result;
    rv_pkg::word_t      rd_wdata;
    logic               rd_we;

    rv_decode_if dec_bus ();

    assign imem_addr = pc;
    assign inst      = imem_rdata;   // same-cycle instruction read

    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .snpc        (snpc)
    );

    decode_unit u_decode (
        .inst (inst),
        .dec  (dec_bus.decoder)
    );

    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .we     (rd_we),
        .waddr  (dec_bus.rd),
        .raddr1 (dec_bus.rs1),
        .raddr2 (dec_bus.rs2),
        .wdata  (rd_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    execute_unit u_execute (
        .dec         (dec_bus.exec),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .pc          (pc),
        .alu_result  (alu_result),
        .jump_target (jump_target),
        .jump_en     (jump_en)
    );

    load_store_unit u_lsu (
        .reset      (reset),
        .dec        (dec_bus.lsu),
        .alu_result (alu_result),
        .rdata2     (rdata2),
        .snpc       (snpc),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .rd_wdata   (rd_wdata),
        .dmem_wmask (dmem_wmask),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .rd_we      (rd_we)
    );

endmodule

/* rv_core_props.sv */
/* rv32i core assertions
   data memory strobe rules, bound to the core */
module rv_core_props (
    input logic               clk,
    input logic               reset,
    input logic               dmem_we,
    input logic               dmem_re,
    input rv_pkg::byte_mask_t dmem_wmask
);
    timeunit 1ns;
    timeprecision 1ps;

    // load and store never share a cycle
    no_read_write: assert property (@(posedge clk) !(dmem_we && dmem_re))
        else $error("dmem_we and dmem_re high together");

    quiet_in_reset: assert property (@(posedge clk) reset |-> !dmem_we)
        else $error("dmem_we high during reset");

    legal_mask: assert property (@(posedge clk)
        dmem_we |-> (dmem_wmask == 4'b0001 || dmem_wmask == 4'b0011 || dmem_wmask == 4'b1111))
        else $error("illegal dmem_wmask %b", dmem_wmask);

endmodule

bind rv_core rv_core_props u_props (
    .clk        (clk),
    .reset      (reset),
    .dmem_we    (dmem_we),
    .dmem_re    (dmem_re),
    .dmem_wmask (dmem_wmask)
);

/* tb_rv_core.sv */
/* rv32i core testbench
   runs the program from rv_tests.txt and checks each data store */
`include "rv_settings.svh"

module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    logic                 clk;
    logic                 reset;
    rv_pkg::word_t        imem_addr;
    rv_pkg::word_t        imem_rdata;
    rv_pkg::word_t        dmem_addr;
    rv_pkg::word_t        dmem_wdata;
    rv_pkg::byte_mask_t   dmem_wmask;
    logic                 dmem_we;
    logic                 dmem_re;
    rv_pkg::word_t        dmem_rdata;

    logic [7:0]           imem [0:1023];   // little-endian bytes
    logic [7:0]           dmem [0:4095];

    string                exp_name [$];
    rv_pkg::word_t        exp_addr [$];
    rv_pkg::word_t        exp_data [$];
    rv_pkg::byte_mask_t   exp_mask [$];

    int                   prog_words = 0;
    int                   seen = 0;
    int                   passed = 0;
    int                   failed = 0;
    int                   errors = 0;
    int                   cycles = 0;
    int                   limit;
    logic                 test_ok;

    rv_core UUT (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wmask (dmem_wmask),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    always #10 clk = ~clk;

    // both memories answer in the same cycle, data memory only while read
    assign imem_rdata = {imem[{imem_addr[9:2], 2'b11}], imem[{imem_addr[9:2], 2'b10}],
                         imem[{imem_addr[9:2], 2'b01}], imem[{imem_addr[9:2], 2'b00}]};
    assign dmem_rdata = dmem_re ?
                        {dmem[{dmem_addr[11:2], 2'b11}], dmem[{dmem_addr[11:2], 2'b10}],
                         dmem[{dmem_addr[11:2], 2'b01}], dmem[{dmem_addr[11:2], 2'b00}]} :
                        'x;

    task automatic check_word(input string name, input string field,
                              input rv_pkg::word_t expected, input rv_pkg::word_t actual);
        if (expected !== actual) begin
            $display("Mismatch %s %s: expected %h, actual %h", name, field, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_mask(input string name, input rv_pkg::byte_mask_t expected,
                              input rv_pkg::byte_mask_t actual);
        if (expected !== actual) begin
            $display("Mismatch %s mask: expected %b, actual %b", name, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic close_test(input string name);
        if (test_ok) begin
            passed++;
            $display("ok   %s", name);
        end else begin
            failed++;
            $display("fail %s", name);
        end
    endtask

    task automatic load_tests();
        int            fd;
        int            code;
        int            base;
        string         tag;
        string         line;
        string         name;
        rv_pkg::word_t a;
        rv_pkg::word_t d;
        rv_pkg::byte_mask_t m;
        fd = $fopen("rv_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open rv_tests.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) break;
            if (tag == "#") begin
                code = $fgets(line, fd);
            end else if (tag == "P") begin
                code = $fscanf(fd, "%h", d);
                for (int k = 0; k < 4; k++) imem[4 * prog_words + k] = d[8*k +: 8];
                prog_words++;
            end else if (tag == "D") begin
                code = $fscanf(fd, "%h %h", a, d);
                base = int'(a[11:0]);
                for (int k = 0; k < 4; k++) dmem[base + k] = d[8*k +: 8];
            end else if (tag == "E") begin
                code = $fscanf(fd, "%s %h %h %h", name, a, d, m);
                exp_name.push_back(name);
                exp_addr.push_back(a);
                exp_data.push_back(d);
                exp_mask.push_back(m);
            end else begin
                $display("unknown line tag %s in rv_tests.txt", tag);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    // store check and memory write at each active edge
    always @(posedge clk) begin
        if (!reset && dmem_we) begin
            if (seen >= exp_name.size()) begin
                $display("unexpected store to %h after the last expected store", dmem_addr);
                errors++;
            end else begin
                test_ok = 1'b1;
                check_word(exp_name[seen], "addr", exp_addr[seen], dmem_addr);
                check_word(exp_name[seen], "data", exp_data[seen], dmem_wdata);
                check_mask(exp_name[seen], exp_mask[seen], dmem_wmask);
                close_test(exp_name[seen]);
                seen++;
            end
            for (int k = 0; k < 4; k++) begin
                if (dmem_wmask[k]) dmem[{dmem_addr[11:2], 2'b00} + k] <= dmem_wdata[8*k +: 8];
            end
        end
    end

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        void'($urandom(32'hbabe_9bda));
        for (int i = 0; i < 1024; i++) imem[i] = 8'(i ^ (i >> 8));
        for (int i = 0; i < 4096; i++) dmem[i] = 8'($urandom);   // unread filler
        load_tests();
        limit = 4 * prog_words + 50;

        repeat (2) @(negedge clk);
        reset = 1'b0;

        test_ok = 1'b1;    // fetch starts at the reset vector
        check_word("reset_pc", "imem_addr", `RV_RESET_PC, imem_addr);
        close_test("reset_pc");

        while (seen < exp_name.size() && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (seen < exp_name.size()) begin
            $display("timeout after %0d cycles, only %0d of %0d expected stores arrived",
                     cycles, seen, exp_name.size());
            errors++;
        end

        $display("tests passed %0d, failed %0d, other errors %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* rv_tests.txt */
# P word | D addr data | E name addr data mask
# x1 = 80001000, x2 = fffffffb, x3 = 3, program from 80000000
D 80001100 9a3c8085
P 00002023
P 800010b7
P ffb00113
P 00300193
P 00310233
P 0040a023
P 40310233
P 0040a223
P 00311233
P 0040a423
P 00312233
P 0040a623
P 00313233
P 0040a823
P 00314233
P 0040aa23
P 00315233
P 0040ac23
P 40315233
P 0040ae23
P 00316233
P 0240a023
P 00317233
P 0240a223
P 00710213
P 0240a423
P 00512213
P 0240a623
P 00513213
P 0240a823
P fff14213
P 0240aa23
P 00416213
P 0240ac23
P 0ff17213
P 0240ae23
P 00411213
P 0440a023
P 00415213
P 0440a223
P 40415213
P 0440a423
P 00318463
P 00202023
P 00314463
P 00202023
P 00317463
P 00202023
P 00316463
P 0430a623
P 00315463
P 0430a823
P 00311463
P 00202023
P 008002ef
P 00202023
P 0450aa23
P 00000397
P 00c38367
P 00202023
P 0460ac23
P 0470ae23
P 0610a023
P 10008203
P 0640a223
P 10009203
P 0640a423
P 1000a203
P 0640a623
P 1000c203
P 0640a823
P 1000d203
P 0640aa23
P 06208c23
P 06209e23
P 0820a023
P 00500013
P 0800a223
P 0000006f
E store_x0 00000000 00000000 f
E add 80001000 fffffffe f
E sub 80001004 fffffff8 f
E sll 80001008 ffffffd8 f
E slt 8000100c 00000001 f
E sltu 80001010 00000000 f
E xor 80001014 fffffff8 f
E srl 80001018 1fffffff f
E sra 8000101c ffffffff f
E or 80001020 fffffffb f
E and 80001024 00000003 f
E addi 80001028 00000002 f
E slti 8000102c 00000001 f
E sltiu 80001030 00000000 f
E xori 80001034 00000004 f
E ori 80001038 ffffffff f
E andi 8000103c 000000fb f
E slli 80001040 ffffffb0 f
E srli 80001044 0fffffff f
E srai 80001048 ffffffff f
E bltu_untaken 8000104c 00000003 f
E bge_untaken 80001050 00000003 f
E jal_link 80001054 800000dc f
E jalr_link 80001058 800000ec f
E auipc 8000105c 800000e4 f
E lui 80001060 80001000 f
E lb 80001064 ffffff85 f
E lh 80001068 ffff8085 f
E lw 8000106c 9a3c8085 f
E lbu 80001070 00000085 f
E lhu 80001074 00008085 f
E sb 80001078 fffffffb 1
E sh 8000107c fffffffb 3
E sw 80001080 fffffffb f
E x0_write 80001084 00000000 f

/* src.f */
+incdir+.
rv_pkg.sv
rv_decode_if.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
execute_unit.sv
load_store_unit.sv
rv_core.sv
rv_core_props.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build and run the rv32i core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_rv_core -o tb_rv_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/tb_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
